//--- src.f
+incdir+include
logic/fp_format_pkg.sv
logic/fp_op_pkg.sv
logic/fp_round_pack.sv
logic/fp_sub.sv
logic/fp_mul.sv
logic/fp_cvt_ws.sv
logic/fp_class.sv
logic/fp_unit.sv
dv/tb_clk_gen.sv
dv/tb_fp_unit.sv

//--- dv/tb_fp_unit.sv
`timescale 1ns/100ps
`include "fp_config.svh"

module tb_fp_unit;

    localparam int N_RAND       = 200;
    // One cycle per operation plus reset and a short drain after each test
    localparam int TOTAL_CYCLES = 2 * N_RAND + 80;

    typedef struct packed {
        logic                  check;
        fp_op_pkg::fp_result_t res;
    } expect_t;

    logic                    clk;
    logic                    rst_n;
    fp_format_pkg::fp_word_t data_r1;
    fp_format_pkg::fp_word_t data_r2;
    logic [`FP_CTRL_W-1:0]   alu_ctrl;
    logic [`FP_WIDTH-1:0]    o_data;
    logic                    o_invalid;
    expect_t                 exp_pend;
    // Starts armed with zeros so the first cycle after reset is checked
    expect_t                 exp_q = {1'b1, 33'd0};
    int                      n_checks = 0;
    int                      n_fail = 0;
    int                      fail_base = 0;

    // One operand per class, in mask bit order
    fp_format_pkg::fp_word_t class_words [10] = '{
        32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000, 32'h0000_0000,
        32'h0040_0000, 32'h3F80_0000, 32'h7F80_0000, 32'h7F80_0001, 32'h7FC0_0000};
    fp_op_pkg::fp_class_e    class_pos [10] = '{
        fp_op_pkg::CLASS_NEG_INF, fp_op_pkg::CLASS_NEG_NORM, fp_op_pkg::CLASS_NEG_SUB,
        fp_op_pkg::CLASS_NEG_ZERO, fp_op_pkg::CLASS_POS_ZERO, fp_op_pkg::CLASS_POS_SUB,
        fp_op_pkg::CLASS_POS_NORM, fp_op_pkg::CLASS_POS_INF, fp_op_pkg::CLASS_SNAN,
        fp_op_pkg::CLASS_QNAN};
    // Halves both signs, small values, 2^31 edge, 1e10, infinities, NaN
    fp_format_pkg::fp_word_t cvt_words [17] = '{
        32'h3F00_0000, 32'h3FC0_0000, 32'h4020_0000, 32'hBF00_0000, 32'hBFC0_0000,
        32'hC020_0000, 32'h3F40_0000, 32'h3E99_999A, 32'h406C_CCCD, 32'hC2C8_8000,
        32'h4EFF_FFFF, 32'h4F00_0000, 32'hCF00_0000, 32'h5015_02F9, 32'h7F80_0000,
        32'hFF80_0000, 32'h7FC0_0000};
    // Zero operand, oversized products of both signs, tiny product
    fp_format_pkg::fp_word_t mul_special [8] = '{
        32'h0000_0000, 32'h3FC0_0000, 32'h7180_0000, 32'h7180_0000,
        32'hF180_0000, 32'h7180_0000, 32'h0D80_0000, 32'h0D80_0000};

    tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

    fp_unit dut (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_data_r1(data_r1), .i_data_r2(data_r2), .i_alu_ctrl(alu_ctrl),
        .o_data(o_data), .o_invalid(o_invalid)
    );

    always @(posedge clk) begin
        if (rst_n) begin
            exp_q <= exp_pend;
            if (exp_q.check) begin
                n_checks <= n_checks + 2;
            end
        end
    end

    data_ok: assert property (@(posedge clk) disable iff (!rst_n)
        exp_q.check |-> o_data == exp_q.res.data)
    else begin
        n_fail++;
        $display("CHECK FAILED at %0t ns: o_data expected %h, got %h", $time,
                 $sampled(exp_q.res.data), $sampled(o_data));
    end

    invalid_ok: assert property (@(posedge clk) disable iff (!rst_n)
        exp_q.check |-> o_invalid == exp_q.res.invalid)
    else begin
        n_fail++;
        $display("CHECK FAILED at %0t ns: o_invalid expected %b, got %b", $time,
                 $sampled(exp_q.res.invalid), $sampled(o_invalid));
    end

    function automatic real pow2(input int e);
        return $bitstoreal({1'b0, 11'(e + 1023), 52'd0});
    endfunction

    function automatic real to_real(input fp_format_pkg::fp_word_t w);
        real mag;
        if (w.exp == '0) begin
            mag = $itor(w.man) * pow2(-149);
        end else begin
            mag = $itor({1'b1, w.man}) * pow2(int'(w.exp) - 150);
        end
        return w.sign ? -mag : mag;
    endfunction

    // Exact value to single precision, nearest even, flush below the normal range
    function automatic fp_op_pkg::fp_result_t round_single(input real x);
        logic [63:0]           d;
        int                    e;
        logic [24:0]           keep;
        fp_op_pkg::fp_result_t r;
        d    = $realtobits(x);
        e    = int'(d[62:52]) - 1023 + `FP_BIAS;
        keep = {2'b01, d[51:29]};
        r    = '0;
        if (x == 0.0) begin
            return r;
        end
        if (e <= 0) begin
            r.invalid = 1'b1;
            return r;
        end
        if (d[28] && ((|d[27:0]) || keep[0])) begin
            keep = keep + 25'd1;
        end
        if (keep[24]) begin
            e = e + 1;
        end
        if (e >= `FP_EXP_MAX) begin
            r.data    = {d[63], 8'hFF, 23'd0};
            r.invalid = 1'b1;
        end else begin
            r.data = {d[63], 8'(e), keep[22:0]};
        end
        return r;
    endfunction

    function automatic fp_op_pkg::fp_result_t cvt_ref(input fp_format_pkg::fp_word_t w);
        real                   x;
        real                   fl;
        longint                v;
        fp_op_pkg::fp_result_t r;
        r.data    = 32'h7FFF_FFFF;
        r.invalid = 1'b1;
        if (w.exp == 8'hFF && w.man != '0) begin
            return r;
        end
        if (w.exp == 8'hFF || int'(w.exp) - `FP_BIAS > 30) begin
            r.data = w.sign ? 32'h8000_0000 : 32'h7FFF_FFFF;
            return r;
        end
        x  = to_real(w);
        fl = $floor(x);
        if (x - fl > 0.5 || (x - fl == 0.5 && longint'(fl) % 2 != 0)) begin
            fl = fl + 1.0;
        end
        v = longint'(fl);
        if (v > 64'sd2147483647) begin
            r.data = 32'h7FFF_FFFF;
        end else if (v < -64'sd2147483648) begin
            r.data = 32'h8000_0000;
        end else begin
            r.data    = v[31:0];
            r.invalid = 1'b0;
        end
        return r;
    endfunction

    function automatic fp_format_pkg::fp_word_t rand_normal(input int exp_val);
        fp_format_pkg::fp_word_t w;
        w.sign = 1'($urandom_range(1));
        w.exp  = 8'(exp_val);
        w.man  = 23'($urandom);
        return w;
    endfunction

    task automatic apply(input fp_format_pkg::fp_word_t a, input fp_format_pkg::fp_word_t b,
                         input logic [`FP_CTRL_W-1:0] ctrl, input fp_op_pkg::fp_result_t res);
        @(posedge clk);
        data_r1  <= a;
        data_r2  <= b;
        alu_ctrl <= ctrl;
        exp_pend <= {1'b1, res};
    endtask

    // Lets the last result reach its check before reporting
    task automatic end_test(input int num, input string name);
        repeat (3) @(posedge clk);
        @(negedge clk);
        $display("Test %0d %s done: %0d failures", num, name, n_fail - fail_base);
        fail_base = n_fail;
    endtask

    initial begin
        fp_format_pkg::fp_word_t a;
        fp_format_pkg::fp_word_t b;
        int                      ea;
        void'($urandom(32'h8637));
        // A NaN conversion is held during reset so both outputs have something to clear
        data_r1  = 32'h7FC0_0000;
        data_r2  = '0;
        alu_ctrl = `FP_OP_CVT;
        exp_pend = '0;

        wait (rst_n === 1'b1);
        end_test(1, "reset");

        for (int i = 0; i < 10; i++) begin
            apply(class_words[i], '0, `FP_OP_CLASS, {32'd1 << class_pos[i], 1'b0});
        end
        end_test(2, "FCLASS");

        for (int i = 0; i < N_RAND; i++) begin
            ea = 30 + $urandom_range(200);
            a  = rand_normal(ea);
            b  = rand_normal(ea + int'($urandom_range(40)) - 20);
            apply(a, b, `FP_OP_SUB, round_single(to_real(a) - to_real(b)));
        end
        apply(a, a, `FP_OP_SUB, round_single(0.0));
        end_test(3, "FSUB");

        for (int i = 0; i < N_RAND; i++) begin
            a = rand_normal(64 + $urandom_range(125));
            b = rand_normal(64 + $urandom_range(125));
            apply(a, b, `FP_OP_MUL, round_single(to_real(a) * to_real(b)));
        end
        for (int i = 0; i < 8; i += 2) begin
            a = mul_special[i];
            b = mul_special[i + 1];
            apply(a, b, `FP_OP_MUL, round_single(to_real(a) * to_real(b)));
        end
        end_test(4, "FMUL");

        for (int i = 0; i < 17; i++) begin
            apply(cvt_words[i], '0, `FP_OP_CVT, cvt_ref(cvt_words[i]));
        end
        end_test(5, "FCVT.W.S");

        apply(32'h3F80_0000, 32'h4000_0000, 5'b00000, '0);
        apply(32'h7FC0_0000, 32'hFF80_0000, 5'b11111, '0);
        apply(32'h4120_0000, 32'h0000_0000, 5'b01101, '0);
        end_test(6, "unknown opcode");

        $display("Checks: %0d passed, %0d failed", n_checks - n_fail, n_fail);
        if (n_fail == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 4 + 200);
        $display("Timeout: tests did not finish within %0d ns", TOTAL_CYCLES * 4 + 200);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD     = 4,
    parameter int RST_CYCLES = 4
) (
    output logic o_clk,
    output logic o_rst_n
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    // Release on a rising edge, like any other driven input
    initial begin
        o_rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

//--- logic/fp_unit.sv
`timescale 1ns/100ps
`include "fp_config.svh"

module fp_unit (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  fp_format_pkg::fp_word_t i_data_r1,
    input  fp_format_pkg::fp_word_t i_data_r2,
    input  logic [`FP_CTRL_W-1:0]   i_alu_ctrl,
    output logic [`FP_WIDTH-1:0]    o_data,
    output logic                    o_invalid
);

    // Hidden bit only for nonzero exponents
    function automatic fp_format_pkg::fp_operand_t unpack(
        input fp_format_pkg::fp_word_t w
    );
        fp_format_pkg::fp_operand_t op;
        op.sign    = w.sign;
        op.exp     = w.exp;
        op.man     = {|w.exp, w.man};
        op.is_zero = (w.exp == '0) && (w.man == '0);
        op.is_inf  = (w.exp == `FP_EXP_MAX) && (w.man == '0);
        op.is_nan  = (w.exp == `FP_EXP_MAX) && (w.man != '0);
        return op;
    endfunction

    fp_format_pkg::fp_operand_t op_a;
    fp_format_pkg::fp_operand_t op_b;
    fp_format_pkg::fp_norm_t    sub_norm;
    fp_format_pkg::fp_norm_t    mul_norm;
    logic                       sub_zero;
    logic                       mul_zero;
    logic [`FP_WIDTH-1:0]       class_mask;
    fp_op_pkg::fp_result_t      sub_res;
    fp_op_pkg::fp_result_t      mul_res;
    fp_op_pkg::fp_result_t      cvt_res;
    fp_op_pkg::fp_result_t      class_res;
    fp_op_pkg::fp_result_t      sel_res;
    fp_op_pkg::fp_result_t      result_q;
    fp_op_pkg::fp_op_e          op;

    assign op_a = unpack(i_data_r1);
    assign op_b = unpack(i_data_r2);
    assign op   = fp_op_pkg::fp_op_e'(i_alu_ctrl);

    fp_sub u_sub (.i_a(op_a), .i_b(op_b), .o_norm(sub_norm), .o_zero(sub_zero));
    fp_round_pack u_sub_round (.i_norm(sub_norm), .i_zero(sub_zero), .o_result(sub_res));

    fp_mul u_mul (.i_a(op_a), .i_b(op_b), .o_norm(mul_norm), .o_zero(mul_zero));
    fp_round_pack u_mul_round (.i_norm(mul_norm), .i_zero(mul_zero), .o_result(mul_res));

    fp_cvt_ws u_cvt (.i_a(op_a), .o_result(cvt_res));
    fp_class  u_class (.i_a(op_a), .o_mask(class_mask));

    assign class_res.data    = class_mask;
    assign class_res.invalid = 1'b0;

    always_comb begin
        case (op)
            fp_op_pkg::OP_FSUB:   sel_res = sub_res;
            fp_op_pkg::OP_FMUL:   sel_res = mul_res;
            fp_op_pkg::OP_FCVT:   sel_res = cvt_res;
            fp_op_pkg::OP_FCLASS: sel_res = class_res;
            default:              sel_res = '0;
        endcase
    end

    // One cycle from operands to result
    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            result_q <= '0;
        end else begin
            result_q <= sel_res;
        end
    end

    assign o_data    = result_q.data;
    assign o_invalid = result_q.invalid;

endmodule

//--- logic/fp_class.sv
`timescale 1ns/100ps
`include "fp_config.svh"

module fp_class (
    input  fp_format_pkg::fp_operand_t i_a,
    output logic [`FP_WIDTH-1:0]       o_mask
);

    fp_op_pkg::fp_class_e cls;

    always_comb begin
        if (i_a.is_nan) begin
            // Quiet NaNs carry the top fraction bit
            cls = i_a.man[`FP_MAN_W-1] ? fp_op_pkg::CLASS_QNAN : fp_op_pkg::CLASS_SNAN;
        end else if (i_a.is_inf) begin
            cls = i_a.sign ? fp_op_pkg::CLASS_NEG_INF : fp_op_pkg::CLASS_POS_INF;
        end else if (i_a.is_zero) begin
            cls = i_a.sign ? fp_op_pkg::CLASS_NEG_ZERO : fp_op_pkg::CLASS_POS_ZERO;
        end else if (i_a.exp == '0) begin
            cls = i_a.sign ? fp_op_pkg::CLASS_NEG_SUB : fp_op_pkg::CLASS_POS_SUB;
        end else begin
            cls = i_a.sign ? fp_op_pkg::CLASS_NEG_NORM : fp_op_pkg::CLASS_POS_NORM;
        end
    end

    assign o_mask = 32'd1 << cls;

endmodule

//--- logic/fp_cvt_ws.sv
`timescale 1ns/100ps
`include "fp_config.svh"

module fp_cvt_ws (
    input  fp_format_pkg::fp_operand_t i_a,
    output fp_op_pkg::fp_result_t      o_result
);

    localparam int FIX_W  = 64;
    localparam int FRAC_W = 32;

    logic signed [9:0]       unb_exp;
    logic [5:0]              shamt;
    logic [FIX_W-1:0]        fixed;
    logic [FIX_W-FRAC_W-1:0] int_part;
    logic                    guard;
    logic                    rest;
    logic [32:0]             magnitude;

    assign unb_exp = $signed({2'b00, i_a.exp}) - 10'(`FP_BIAS);

    // Fixed point with 32 fraction bits, mantissa LSB sits at 2^(e-23)
    assign shamt = 6'(unb_exp + 10'sd9);
    assign fixed = {{(FIX_W-`FP_MAN_W-1){1'b0}}, i_a.man} << shamt;

    assign int_part = fixed[FIX_W-1:FRAC_W];
    assign guard    = fixed[FRAC_W-1];
    assign rest     = |fixed[FRAC_W-2:0];

    // Ties go to the even integer
    assign magnitude = {1'b0, int_part} + {32'd0, guard & (rest | int_part[0])};

    always_comb begin
        o_result = '0;
        if (i_a.is_nan) begin
            o_result.data    = 32'h7FFF_FFFF;
            o_result.invalid = 1'b1;
        end else if (i_a.is_inf || unb_exp > 10'sd30) begin
            o_result.data    = i_a.sign ? 32'h8000_0000 : 32'h7FFF_FFFF;
            o_result.invalid = 1'b1;
        end else if (unb_exp < -10'sd1) begin
            // Below one half always rounds to zero
            o_result.data = '0;
        end else if (i_a.sign) begin
            if (magnitude > 33'h0_8000_0000) begin
                o_result.data    = 32'h8000_0000;
                o_result.invalid = 1'b1;
            end else begin
                o_result.data = ~magnitude[31:0] + 32'd1;
            end
        end else begin
            if (magnitude > 33'h0_7FFF_FFFF) begin
                o_result.data    = 32'h7FFF_FFFF;
                o_result.invalid = 1'b1;
            end else begin
                o_result.data = magnitude[31:0];
            end
        end
    end

endmodule

//--- logic/fp_mul.sv
`timescale 1ns/100ps
`include "fp_config.svh"

module fp_mul (
    input  fp_format_pkg::fp_operand_t i_a,
    input  fp_format_pkg::fp_operand_t i_b,
    output fp_format_pkg::fp_norm_t    o_norm,
    output logic                       o_zero
);

    localparam int PROD_W = 2 * (`FP_MAN_W + 1);
    // Bits taken above the sticky position
    localparam int KEEP_W = `FP_NORM_W - 1;

    logic [PROD_W-1:0] product;
    logic signed [9:0] exp_sum;

    assign product = i_a.man * i_b.man;
    assign exp_sum = $signed({2'b00, i_a.exp}) + $signed({2'b00, i_b.exp}) - 10'(`FP_BIAS);

    always_comb begin
        o_norm.sign = i_a.sign ^ i_b.sign;
        if (product[PROD_W-1]) begin
            // Product in [2,4) needs one step right
            o_norm.exp = exp_sum + 10'sd1;
            o_norm.man = {product[PROD_W-1 -: KEEP_W], |product[PROD_W-KEEP_W-1:0]};
        end else begin
            o_norm.exp = exp_sum;
            o_norm.man = {product[PROD_W-2 -: KEEP_W], |product[PROD_W-KEEP_W-2:0]};
        end
    end

    assign o_zero = i_a.is_zero | i_b.is_zero;

endmodule

//--- logic/fp_sub.sv
`timescale 1ns/100ps
`include "fp_config.svh"

module fp_sub (
    input  fp_format_pkg::fp_operand_t i_a,
    input  fp_format_pkg::fp_operand_t i_b,
    output fp_format_pkg::fp_norm_t    o_norm,
    output logic                       o_zero
);

    logic                  b_sign;
    logic                  a_larger;
    logic [`FP_EXP_W-1:0]  exp_big;
    logic [`FP_EXP_W-1:0]  exp_diff;
    logic [`FP_NORM_W-1:0] man_big;
    logic [`FP_NORM_W-1:0] man_small;
    logic [`FP_NORM_W-1:0] lost_mask;
    logic                  sticky;
    logic [`FP_NORM_W-1:0] man_aligned;
    logic [`FP_NORM_W:0]   sum;
    logic [4:0]            lead_zeros;

    // Subtraction is addition of b with its sign flipped
    assign b_sign = ~i_b.sign;

    // Order by magnitude so the difference never goes negative
    assign a_larger  = {i_a.exp, i_a.man} >= {i_b.exp, i_b.man};
    assign exp_big   = a_larger ? i_a.exp : i_b.exp;
    assign exp_diff  = a_larger ? (i_a.exp - i_b.exp) : (i_b.exp - i_a.exp);
    assign man_big   = a_larger ? {i_a.man, {`FP_GRS_W{1'b0}}} : {i_b.man, {`FP_GRS_W{1'b0}}};
    assign man_small = a_larger ? {i_b.man, {`FP_GRS_W{1'b0}}} : {i_a.man, {`FP_GRS_W{1'b0}}};

    // Every bit shifted past the LSB folds into sticky
    assign lost_mask   = ~({`FP_NORM_W{1'b1}} << exp_diff);
    assign sticky      = |(man_small & lost_mask);
    assign man_aligned = (man_small >> exp_diff) | {{(`FP_NORM_W-1){1'b0}}, sticky};

    always_comb begin
        if (i_a.sign == b_sign) begin
            sum = {1'b0, man_big} + {1'b0, man_aligned};
        end else begin
            sum = {1'b0, man_big} - {1'b0, man_aligned};
        end
    end

    // Priority search, the highest set bit wins
    always_comb begin
        lead_zeros = '0;
        for (int i = 0; i < `FP_NORM_W; i++) begin
            if (sum[i]) begin
                lead_zeros = 5'(`FP_NORM_W - 1 - i);
            end
        end
    end

    always_comb begin
        o_norm.sign = a_larger ? i_a.sign : b_sign;
        if (sum[`FP_NORM_W]) begin
            // Carry out, shift right and keep the dropped bit as sticky
            o_norm.exp = $signed({2'b00, exp_big}) + 10'sd1;
            o_norm.man = {sum[`FP_NORM_W:2], sum[1] | sum[0]};
        end else begin
            o_norm.exp = $signed({2'b00, exp_big}) - $signed({5'b00000, lead_zeros});
            o_norm.man = sum[`FP_NORM_W-1:0] << lead_zeros;
        end
    end

    assign o_zero = (sum == '0);

endmodule

//--- logic/fp_round_pack.sv
`timescale 1ns/100ps
`include "fp_config.svh"

module fp_round_pack (
    input  fp_format_pkg::fp_norm_t i_norm,
    input  logic                    i_zero,
    output fp_op_pkg::fp_result_t   o_result
);

    logic signed [9:0]    exp_in;
    logic [`FP_MAN_W-1:0] frac;
    logic                 lsb;
    logic                 guard;
    logic                 rest;
    logic                 round_up;
    logic [`FP_MAN_W:0]   frac_inc;
    logic [`FP_EXP_W-1:0] exp_out;

    assign exp_in = i_norm.exp;
    assign frac   = i_norm.man[`FP_NORM_W-2:`FP_GRS_W];
    assign lsb    = i_norm.man[`FP_GRS_W];
    assign guard  = i_norm.man[`FP_GRS_W-1];
    assign rest   = |i_norm.man[`FP_GRS_W-2:0];

    // Round up above half, or on a tie when the kept LSB is odd
    assign round_up = guard & (rest | lsb);
    assign frac_inc = {1'b0, frac} + {{`FP_MAN_W{1'b0}}, round_up};

    // Carry out of the fraction bumps the exponent
    assign exp_out = exp_in[`FP_EXP_W-1:0] + {{(`FP_EXP_W-1){1'b0}}, frac_inc[`FP_MAN_W]};

    always_comb begin
        o_result = '0;
        if (i_zero) begin
            o_result.data = '0;
        end else if (exp_in >= `FP_EXP_MAX) begin
            o_result.data    = {i_norm.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
            o_result.invalid = 1'b1;
        end else if (exp_in <= 0) begin
            // Subnormal range flushes to +0
            o_result.data    = '0;
            o_result.invalid = 1'b1;
        end else if (exp_out == `FP_EXP_MAX) begin
            // Rounding carried into the reserved exponent
            o_result.data    = {i_norm.sign, {`FP_EXP_W{1'b1}}, {`FP_MAN_W{1'b0}}};
            o_result.invalid = 1'b1;
        end else begin
            o_result.data = {i_norm.sign, exp_out, frac_inc[`FP_MAN_W-1:0]};
        end
    end

endmodule

//--- logic/fp_op_pkg.sv
`include "fp_config.svh"

package fp_op_pkg;

    typedef enum logic [`FP_CTRL_W-1:0] {
        OP_FSUB   = `FP_OP_SUB,
        OP_FMUL   = `FP_OP_MUL,
        OP_FCVT   = `FP_OP_CVT,
        OP_FCLASS = `FP_OP_CLASS
    } fp_op_e;

    // Bit positions of the FCLASS mask
    typedef enum logic [3:0] {
        CLASS_NEG_INF  = 4'd0,
        CLASS_NEG_NORM = 4'd1,
        CLASS_NEG_SUB  = 4'd2,
        CLASS_NEG_ZERO = 4'd3,
        CLASS_POS_ZERO = 4'd4,
        CLASS_POS_SUB  = 4'd5,
        CLASS_POS_NORM = 4'd6,
        CLASS_POS_INF  = 4'd7,
        CLASS_SNAN     = 4'd8,
        CLASS_QNAN     = 4'd9
    } fp_class_e;

    typedef struct packed {
        logic [`FP_WIDTH-1:0] data;
        logic                 invalid;
    } fp_result_t;

endpackage

//--- logic/fp_format_pkg.sv
`include "fp_config.svh"

package fp_format_pkg;

    // Single precision word as it sits in a register
    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exp;
        logic [`FP_MAN_W-1:0] man;
    } fp_word_t;

    // Unpacked operand with the hidden bit restored
    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exp;
        logic [`FP_MAN_W:0]   man;
        logic                 is_zero;
        logic                 is_inf;
        logic                 is_nan;
    } fp_operand_t;

    // Normalized result before rounding, mantissa LSB is the sticky bit
    typedef struct packed {
        logic                  sign;
        logic signed [9:0]     exp;
        logic [`FP_NORM_W-1:0] man;
    } fp_norm_t;

endpackage

//--- include/fp_config.svh
`ifndef FP_CONFIG_SVH
`define FP_CONFIG_SVH

// IEEE 754 single precision field widths
`define FP_WIDTH    32
`define FP_EXP_W    8
`define FP_MAN_W    23
`define FP_BIAS     127
`define FP_EXP_MAX  255

// Guard, round and sticky bits kept below the fraction
`define FP_GRS_W    3
// Hidden bit, stored fraction and GRS bits
`define FP_NORM_W   27

// ALU control codes
`define FP_CTRL_W   5
`define FP_OP_SUB   5'b01010
`define FP_OP_MUL   5'b01011
`define FP_OP_CVT   5'b01100
`define FP_OP_CLASS 5'b01111

`endif
